// File: src.f
logic/isa_pkg.sv
logic/thread_pkg.sv
logic/issue_if.sv
logic/wb_if.sv
logic/slice_sequencer.sv
logic/reg_file.sv
logic/arith_unit.sv
logic/exec_cluster_top.sv
testbench/tb_exec_cluster.sv

// File: testbench/tb_exec_cluster.sv
`timescale 1ns/1ps

module tb_exec_cluster;
  import isa_pkg::*;
  import thread_pkg::*;

  localparam int BUF_DEPTH = 2;
  localparam int MAX_ROWS  = 128;
  localparam int NUM_RAND  = 64;

  logic        CLK;
  logic        RST;
  logic        in_vld;
  slice_t      in_slice;
  word_t       in_word;
  logic        crd_vld;
  slice_t      crd_slice;
  logic        res_vld;
  slice_t      res_slice;
  logic        res_wr;
  reg_idx_t    res_sel;
  logic [31:0] res_data;
  flags_t      res_flags;

  // Stimulus table and expected results
  int          n_rows;
  int          row_slice [MAX_ROWS];
  logic [31:0] row_word  [MAX_ROWS];
  logic        exp_wr    [MAX_ROWS];
  logic [31:0] exp_data  [MAX_ROWS];
  logic [3:0]  exp_flags [MAX_ROWS];
  int          exp_rows  [NUM_SLICES][MAX_ROWS];
  int          n_exp     [NUM_SLICES];
  int          n_got     [NUM_SLICES];
  int          credits   [NUM_SLICES];

  // Reference state per slice
  logic [31:0] regs_m [NUM_SLICES][NUM_REGS];
  logic [27:0] imm_m  [NUM_SLICES];
  logic [3:0]  flg_m  [NUM_SLICES];
  logic [31:0] lcg_state;

  exec_cluster_top #(
    .BUF_DEPTH (BUF_DEPTH)
  ) dut (
    .CLK       (CLK),
    .RST       (RST),
    .in_vld    (in_vld),
    .in_slice  (in_slice),
    .in_word   (in_word),
    .crd_vld   (crd_vld),
    .crd_slice (crd_slice),
    .res_vld   (res_vld),
    .res_slice (res_slice),
    .res_wr    (res_wr),
    .res_sel   (res_sel),
    .res_data  (res_data),
    .res_flags (res_flags)
  );

  initial
  begin
    CLK = 1'b0;
  end

  always #20 CLK = ~CLK;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [31:0] op_w(input logic f, input logic [4:0] opc,
                                       input int ra, input int rb, input int rc);
    return {17'd0, f, opc, 3'(ra), 3'(rb), 3'(rc)};
  endfunction

  function automatic logic [31:0] imm_w(input logic [27:0] v);
    return {4'h8, v};
  endfunction

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    assert (got === exp)
    else
    begin
      $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
      $display("Checks failed");
      $fatal(1, "Value mismatch on %s", name);
    end
  endtask

  // Reference model of one word for one slice
  task automatic model_step(input int s, input logic [31:0] w, output logic v,
                            output logic wr, output logic [31:0] d, output logic [3:0] f);
    logic [4:0]  opc;
    logic [31:0] a;
    logic [31:0] b;
    logic [2:0]  n;
    logic [32:0] wide;
    logic [32:0] exact;
    v  = 1'b0;
    wr = 1'b0;
    d  = '0;
    f  = flg_m[s];
    if (w[31])
    begin
      imm_m[s] = w[27:0];
      return;
    end
    opc = w[14] ? {1'b0, w[12:9]} : w[13:9];
    a   = regs_m[s][w[8:6]];
    b   = w[14] ? {imm_m[s], w[13], w[5:3]} : regs_m[s][w[5:3]];
    n   = (opc[4] && opc[3]) ? regs_m[s][w[5:3]][2:0] : w[5:3];
    if (opc[4])
    begin
      opc[3] = 1'b0;
      if ((opc == OP_ADDI) || (opc == OP_SUBI))
        b = {29'd0, n};
    end
    case (opc)
      OP_OR:   d = a | b;
      OP_XOR:  d = a ^ b;
      OP_AND:  d = a & b;
      OP_ADD, OP_ADDI:
      begin
        wide         = {1'b0, a} + {1'b0, b};
        d            = wide[31:0];
        // Exact signed sum needs 33 bits
        exact        = {a[31], a} + {b[31], b};
        f[FLG_SOVFL] = (exact[32] != exact[31]);
        f[FLG_UOVFL] = wide[32];
      end
      OP_SUB, OP_SUBI, OP_CMP:
      begin
        d            = a - b;
        exact        = {a[31], a} - {b[31], b};
        f[FLG_SOVFL] = (exact[32] != exact[31]);
        f[FLG_UOVFL] = (a < b);
      end
      OP_BSET: d = a | (32'd1 << n);
      OP_BCLR: d = a & ~(32'd1 << n);
      OP_SHL:  d = a << n;
      OP_SHR:  d = a >> n;
      OP_ASR:  d = $signed(a) >>> n;
      OP_SEXT:
      begin
        case (n[1:0])
          2'd0:    d = {32{a[0]}};
          2'd1:    d = {{24{a[7]}}, a[7:0]};
          2'd2:    d = {{16{a[15]}}, a[15:0]};
          default: d = {{8{a[23]}}, a[23:0]};
        endcase
      end
      default: d = '0;
    endcase
    f[FLG_ZERO] = (d == 32'd0);
    f[FLG_NEG]  = d[31];
    v  = 1'b1;
    wr = (opc != OP_CMP);
    if (wr)
      regs_m[s][w[2:0]] = d;
    flg_m[s] = f;
  endtask

  task automatic push_row(input int s, input logic [31:0] w, input logic v,
                          input logic wr, input logic [31:0] d, input logic [3:0] f);
    row_slice[n_rows] = s;
    row_word[n_rows]  = w;
    exp_wr[n_rows]    = wr;
    exp_data[n_rows]  = d;
    exp_flags[n_rows] = f;
    if (v)
    begin
      exp_rows[s][n_exp[s]] = n_rows;
      n_exp[s]++;
    end
    n_rows++;
  endtask

  // Hand-computed expected values while the model only tracks state
  task automatic table_row(input int s, input logic [31:0] w, input logic wr,
                           input logic [31:0] d, input logic [3:0] f);
    logic        v;
    logic        m_wr;
    logic [31:0] m_d;
    logic [3:0]  m_f;
    model_step(s, w, v, m_wr, m_d, m_f);
    push_row(s, w, !w[31], wr, d, f);
  endtask

  task automatic load_table();
    table_row(0, op_w(0, OP_ADD, 0, 0, 1), 1, 32'h00000000, 4'h1);
    table_row(0, imm_w(28'h1234567), 0, 0, 0);
    table_row(0, op_w(1, OP_ADDI, 0, 5, 2), 1, 32'h1234567D, 4'h0);
    table_row(0, imm_w(28'h0F0F0F0), 0, 0, 0);
    table_row(0, op_w(1, OP_ADDI, 0, 0, 3), 1, 32'h0F0F0F08, 4'h0);
    table_row(0, op_w(0, OP_OR, 2, 3, 4), 1, 32'h1F3F5F7D, 4'h0);
    table_row(0, op_w(0, OP_XOR, 2, 3, 5), 1, 32'h1D3B5975, 4'h0);
    table_row(0, op_w(0, OP_AND, 2, 3, 6), 1, 32'h02040608, 4'h0);
    table_row(0, op_w(0, OP_ADD, 2, 3, 7), 1, 32'h21436585, 4'h0);
    table_row(0, op_w(0, OP_SUB, 3, 2, 1), 1, 32'hFCDAB88B, 4'hA);
    // Compare leaves r4 alone and the next row reads it back
    table_row(0, op_w(0, OP_CMP, 2, 2, 4), 0, 32'h00000000, 4'h1);
    table_row(0, op_w(0, OP_OR, 4, 4, 5), 1, 32'h1F3F5F7D, 4'h0);
    table_row(0, op_w(0, OP_BSET, 0, 7, 1), 1, 32'h00000080, 4'h0);
    table_row(0, op_w(0, OP_BCLR | OP_REG_AMT, 4, 2, 6), 1, 32'h1F3F5F5D, 4'h0);
    table_row(0, op_w(0, OP_SHL, 3, 4, 7), 1, 32'hF0F0F080, 4'h2);
    table_row(0, op_w(0, OP_SHR | OP_REG_AMT, 7, 2, 1), 1, 32'h07878784, 4'h0);
    table_row(0, op_w(0, OP_ASR, 7, 4, 1), 1, 32'hFF0F0F08, 4'h2);
    table_row(0, op_w(0, OP_SEXT | OP_REG_AMT, 2, 3, 5), 1, 32'hFFFFFFFF, 4'h2);
    // Flag corners
    table_row(0, imm_w(28'h7FFFFFF), 0, 0, 0);
    table_row(0, op_w(1, OP_ADDI, 0, 7, 3), 1, 32'h7FFFFFFF, 4'h0);
    table_row(0, op_w(0, OP_ADDI, 3, 1, 4), 1, 32'h80000000, 4'h6);
    table_row(0, op_w(0, OP_SUBI, 0, 1, 7), 1, 32'hFFFFFFFF, 4'hA);
    table_row(0, op_w(0, OP_SUB, 3, 3, 1), 1, 32'h00000000, 4'h1);
  endtask

  // Slices in bursts of BUF_DEPTH so buffers fill up
  task automatic load_random();
    logic [31:0] r;
    logic [31:0] w;
    logic        v;
    logic        wr;
    logic [31:0] d;
    logic [3:0]  f;
    int          s;
    for (int i = 0; i < NUM_RAND; i++)
    begin
      s = (i / BUF_DEPTH) % NUM_SLICES;
      r = lcg_next();
      if (r[31:30] == 2'd0)
      begin
        r = lcg_next();
        w = imm_w(r[31:4]);
      end
      else
        w = {17'd0, r[28:14]};
      model_step(s, w, v, wr, d, f);
      push_row(s, w, v, wr, d, f);
    end
  endtask

  function automatic bit all_done();
    for (int s = 0; s < NUM_SLICES; s++)
    begin
      if ((n_got[s] != n_exp[s]) || (credits[s] != BUF_DEPTH))
        return 1'b0;
    end
    return 1'b1;
  endfunction

  always @(posedge CLK)
  begin
    if (!RST && crd_vld)
    begin
      assert (credits[crd_slice] < BUF_DEPTH)
      else
      begin
        $display("Credit returned on slice %0d with no word outstanding", crd_slice);
        $display("Checks failed");
        $fatal(1, "Extra credit");
      end
      credits[crd_slice]++;
    end
  end

  always @(posedge CLK)
  begin : match_results
    int idx;
    if (!RST && res_vld)
    begin
      assert (n_got[res_slice] < n_exp[res_slice])
      else
      begin
        $display("Result arrived on slice %0d with no operation pending", res_slice);
        $display("Checks failed");
        $fatal(1, "Unexpected result");
      end
      idx = exp_rows[res_slice][n_got[res_slice]];
      check_val("res_wr", res_wr, exp_wr[idx]);
      check_val("res_sel", res_sel, row_word[idx][2:0]);
      check_val("res_data", res_data, exp_data[idx]);
      check_val("res_flags", res_flags, exp_flags[idx]);
      n_got[res_slice]++;
    end
  end

  // Watchdog sized from the number of words
  initial
  begin
    @(negedge RST);
    repeat (20 * n_rows + 100) @(posedge CLK);
    $display("Watchdog timeout with results or credits still outstanding");
    $display("Checks failed");
    $fatal(1, "Timeout");
  end

  initial
  begin
    RST       = 1'b1;
    in_vld    = 1'b0;
    in_slice  = '0;
    in_word   = '0;
    lcg_state = 32'd87322;
    n_rows    = 0;
    for (int s = 0; s < NUM_SLICES; s++)
    begin
      n_exp[s]   = 0;
      n_got[s]   = 0;
      credits[s] = BUF_DEPTH;
      imm_m[s]   = '0;
      flg_m[s]   = '0;
      for (int r = 0; r < NUM_REGS; r++)
        regs_m[s][r] = '0;
    end
    load_table();
    load_random();
    repeat (3) @(posedge CLK);
    #2 RST = 1'b0;
    // Quiet outputs before any word is sent
    repeat (4)
    begin
      @(posedge CLK);
      check_val("crd_vld", crd_vld, 1'b0);
      check_val("res_vld", res_vld, 1'b0);
      check_val("res_wr", res_wr, 1'b0);
    end
    #2;
    for (int i = 0; i < n_rows; i++)
    begin
      while (credits[row_slice[i]] == 0)
      begin
        in_vld = 1'b0;
        @(posedge CLK);
        #2;
      end
      in_vld   = 1'b1;
      in_slice = slice_t'(row_slice[i]);
      in_word  = row_word[i];
      credits[row_slice[i]]--;
      @(posedge CLK);
      #2;
    end
    in_vld = 1'b0;
    while (!all_done())
    begin
      @(posedge CLK);
      #2;
    end
    $display("All checks passed");
    $finish;
  end

endmodule

// File: logic/exec_cluster_top.sv
`timescale 1ns/1ps

module exec_cluster_top #(
  parameter int BUF_DEPTH = 2
) (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 in_vld,
  input  thread_pkg::slice_t   in_slice,
  input  isa_pkg::word_t       in_word,
  output logic                 crd_vld,
  output thread_pkg::slice_t   crd_slice,
  output logic                 res_vld,
  output thread_pkg::slice_t   res_slice,
  output logic                 res_wr,
  output thread_pkg::reg_idx_t res_sel,
  output logic [31:0]          res_data,
  output isa_pkg::flags_t      res_flags
);
  import thread_pkg::*;

  reg_idx_t    ra_sel;
  reg_idx_t    rb_sel;
  logic [31:0] ra_data;
  logic [31:0] rb_data;

  issue_if iss ();
  wb_if    wb ();

  slice_sequencer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) u_seq (
    .CLK       (CLK),
    .RST       (RST),
    .in_vld    (in_vld),
    .in_slice  (in_slice),
    .in_word   (in_word),
    .crd_vld   (crd_vld),
    .crd_slice (crd_slice),
    .iss       (iss.sequencer)
  );

  // Register reads follow the issuing slice
  reg_file u_rf (
    .CLK      (CLK),
    .RST      (RST),
    .rd_slice (iss.slice),
    .ra_sel   (ra_sel),
    .rb_sel   (rb_sel),
    .ra       (ra_data),
    .rb       (rb_data),
    .wb       (wb.sink)
  );

  arith_unit u_au (
    .CLK    (CLK),
    .RST    (RST),
    .iss    (iss.unit),
    .ra_sel (ra_sel),
    .rb_sel (rb_sel),
    .ra     (ra_data),
    .rb     (rb_data),
    .wb     (wb.unit)
  );

  // Completion report
  assign res_vld   = wb.vld;
  assign res_slice = wb.slice;
  assign res_wr    = wb.wr;
  assign res_sel   = wb.sel;
  assign res_data  = wb.data;
  assign res_flags = wb.flags;

endmodule

// File: logic/arith_unit.sv
`timescale 1ns/1ps

module arith_unit (
  input  logic                 CLK,
  input  logic                 RST,
  issue_if.unit                iss,
  output thread_pkg::reg_idx_t ra_sel,
  output thread_pkg::reg_idx_t rb_sel,
  input  logic [31:0]          ra,
  input  logic [31:0]          rb,
  wb_if.unit                   wb
);
  import isa_pkg::*;
  import thread_pkg::*;

  imm_t        imm_hold [NUM_SLICES];
  flags_t      flag_q   [NUM_SLICES];
  op_word_t    op;
  logic [4:0]  opc;
  logic [31:0] imm_b;

  // Stage one
  logic        s1_vld;
  au_op_e      s1_op;
  logic [31:0] s1_a;
  logic [31:0] s1_b;
  logic [2:0]  s1_amt;
  reg_idx_t    s1_rc;
  slice_t      s1_slice;

  // Stage two
  logic        s2_vld;
  logic        s2_wr;
  logic [31:0] s2_data;
  flags_t      s2_flags;
  reg_idx_t    s2_rc;
  slice_t      s2_slice;

  // Stage two combinational
  logic [31:0] add_b;
  logic [32:0] sum;
  logic [32:0] diff;
  logic [31:0] bit_mask;
  logic [31:0] result;
  logic        is_arith;
  logic        ovf_s;
  logic        ovf_u;
  flags_t      new_flags;

  // Immediate prefix per slice
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int s = 0; s < NUM_SLICES; s++)
        imm_hold[s] <= '0;
    end
    else if (iss.imm_vld)
    begin
      imm_hold[iss.slice] <= iss.imm;
    end
  end

  // Decode
  assign op     = iss.op;
  assign opc    = op.imm_form ? (op.opcode & OP_IMM_MASK) : op.opcode;
  assign imm_b  = {imm_hold[iss.slice], op.opcode[4], op.rb};
  assign ra_sel = op.ra;
  assign rb_sel = op.rb;

  always_ff @(posedge CLK)
  begin
    if (iss.op_vld)
    begin
      s1_a     <= ra;
      s1_b     <= op.imm_form ? imm_b : rb;
      // Bit class with 0x08 set takes its amount from register rb
      s1_amt   <= (opc[4] && opc[3]) ? rb[2:0] : op.rb;
      s1_op    <= au_op_e'(opc[4] ? (opc & ~OP_REG_AMT) : opc);
      s1_rc    <= op.rc;
      s1_slice <= iss.slice;
    end
  end

  always_comb
  begin
    add_b     = ((s1_op == OP_ADDI) || (s1_op == OP_SUBI)) ? {29'd0, s1_amt} : s1_b;
    sum       = {1'b0, s1_a} + {1'b0, add_b};
    diff      = {1'b0, s1_a} - {1'b0, add_b};
    bit_mask  = 32'd1 << s1_amt;
    is_arith  = 1'b0;
    ovf_s     = 1'b0;
    ovf_u     = 1'b0;
    case (s1_op)
      OP_OR:   result = s1_a | s1_b;
      OP_XOR:  result = s1_a ^ s1_b;
      OP_AND:  result = s1_a & s1_b;
      OP_ADD, OP_ADDI:
      begin
        result   = sum[31:0];
        is_arith = 1'b1;
        ovf_u    = sum[32];
        ovf_s    = (s1_a[31] == add_b[31]) && (sum[31] != s1_a[31]);
      end
      OP_SUB, OP_SUBI, OP_CMP:
      begin
        result   = diff[31:0];
        is_arith = 1'b1;
        // Top bit of the wide difference is the borrow
        ovf_u    = diff[32];
        ovf_s    = (s1_a[31] != add_b[31]) && (diff[31] != s1_a[31]);
      end
      OP_BSET: result = s1_a | bit_mask;
      OP_BCLR: result = s1_a & ~bit_mask;
      OP_SHL:  result = s1_a << s1_amt;
      OP_SHR:  result = s1_a >> s1_amt;
      OP_ASR:  result = $signed(s1_a) >>> s1_amt;
      OP_SEXT:
      begin
        case (s1_amt[1:0])
          2'd0:    result = {32{s1_a[0]}};
          2'd1:    result = {{24{s1_a[7]}}, s1_a[7:0]};
          2'd2:    result = {{16{s1_a[15]}}, s1_a[15:0]};
          default: result = {{8{s1_a[23]}}, s1_a[23:0]};
        endcase
      end
      default: result = 32'd0;
    endcase

    // Overflow bits hold their old value unless an add or subtract ran
    new_flags = flag_q[s1_slice];
    new_flags[FLG_ZERO] = (result == 32'd0);
    new_flags[FLG_NEG]  = result[31];
    if (is_arith)
    begin
      new_flags[FLG_SOVFL] = ovf_s;
      new_flags[FLG_UOVFL] = ovf_u;
    end
  end

  always_ff @(posedge CLK)
  begin
    if (s1_vld)
    begin
      s2_data  <= result;
      s2_flags <= new_flags;
      s2_rc    <= s1_rc;
      s2_slice <= s1_slice;
    end
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      s1_vld <= 1'b0;
      s2_vld <= 1'b0;
      s2_wr  <= 1'b0;
    end
    else
    begin
      s1_vld <= iss.op_vld;
      s2_vld <= s1_vld;
      // Compare only reports flags
      s2_wr  <= s1_vld && (s1_op != OP_CMP);
    end
  end

  // Flags land in the slice register with the result
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int s = 0; s < NUM_SLICES; s++)
        flag_q[s] <= '0;
    end
    else if (s2_vld)
    begin
      flag_q[s2_slice] <= s2_flags;
    end
  end

  assign wb.vld   = s2_vld;
  assign wb.wr    = s2_wr;
  assign wb.slice = s2_slice;
  assign wb.sel   = s2_rc;
  assign wb.data  = s2_data;
  assign wb.flags = s2_flags;

  a_wb_latency: assert property (@(posedge CLK) disable iff (RST)
    iss.op_vld |-> ##2 wb.vld);

  a_wb_source: assert property (@(posedge CLK) disable iff (RST)
    wb.vld |-> $past(iss.op_vld, 2));

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                 CLK,
  input  logic                 RST,
  input  thread_pkg::slice_t   rd_slice,
  input  thread_pkg::reg_idx_t ra_sel,
  input  thread_pkg::reg_idx_t rb_sel,
  output logic [31:0]          ra,
  output logic [31:0]          rb,
  wb_if.sink                   wb
);
  import thread_pkg::*;

  // One bank of registers per slice
  logic [31:0] regs [NUM_SLICES][NUM_REGS];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int s = 0; s < NUM_SLICES; s++)
      begin
        for (int r = 0; r < NUM_REGS; r++)
          regs[s][r] <= '0;
      end
    end
    else if (wb.vld && wb.wr)
    begin
      regs[wb.slice][wb.sel] <= wb.data;
    end
  end

  // Reads for the issuing slice, same cycle
  assign ra = regs[rd_slice][ra_sel];
  assign rb = regs[rd_slice][rb_sel];

endmodule

// File: logic/slice_sequencer.sv
`timescale 1ns/1ps

module slice_sequencer #(
  parameter int BUF_DEPTH = 2
) (
  input  logic               CLK,
  input  logic               RST,
  input  logic               in_vld,
  input  thread_pkg::slice_t in_slice,
  input  isa_pkg::word_t     in_word,
  output logic               crd_vld,
  output thread_pkg::slice_t crd_slice,
  issue_if.sequencer         iss
);
  import isa_pkg::*;
  import thread_pkg::*;

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  slice_t                cur_slice;
  word_t                 buf_mem [NUM_SLICES][BUF_DEPTH];
  logic [PTR_W-1:0]      wr_ptr  [NUM_SLICES];
  logic [PTR_W-1:0]      rd_ptr  [NUM_SLICES];
  logic [CNT_W-1:0]      fill    [NUM_SLICES];
  logic [NUM_SLICES-1:0] push;
  logic [NUM_SLICES-1:0] pop;
  logic                  head_vld;
  word_t                 head_word;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(BUF_DEPTH - 1))
      return '0;
    return p + 1'b1;
  endfunction

  // Free-running slot owner
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      cur_slice <= '0;
    else
      cur_slice <= cur_slice + 1'b1;
  end

  // Head of the current slice's buffer
  assign head_vld  = (fill[cur_slice] != '0);
  assign head_word = buf_mem[cur_slice][rd_ptr[cur_slice]];

  always_comb
  begin
    for (int s = 0; s < NUM_SLICES; s++)
    begin
      push[s] = in_vld && (in_slice == slice_t'(s));
      pop[s]  = head_vld && (cur_slice == slice_t'(s));
    end
  end

  always_ff @(posedge CLK)
  begin
    if (in_vld)
      buf_mem[in_slice][wr_ptr[in_slice]] <= in_word;
  end

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int s = 0; s < NUM_SLICES; s++)
      begin
        wr_ptr[s] <= '0;
        rd_ptr[s] <= '0;
        fill[s]   <= '0;
      end
    end
    else
    begin
      for (int s = 0; s < NUM_SLICES; s++)
      begin
        if (push[s])
          wr_ptr[s] <= next_ptr(wr_ptr[s]);
        if (pop[s])
          rd_ptr[s] <= next_ptr(rd_ptr[s]);
        // Push and pop together leave the fill level alone
        if (push[s] && !pop[s])
          fill[s] <= fill[s] + 1'b1;
        else if (pop[s] && !push[s])
          fill[s] <= fill[s] - 1'b1;
      end
    end
  end

  // Split head word into an operation or an immediate slot
  assign iss.slice   = cur_slice;
  assign iss.op_vld  = head_vld && !head_word[IMM_BIT];
  assign iss.op      = head_word[OP_W-1:0];
  assign iss.imm_vld = head_vld && head_word[IMM_BIT];
  assign iss.imm     = head_word[IMM_W-1:0];

  // One credit back per issued word
  assign crd_vld   = head_vld;
  assign crd_slice = cur_slice;

  // Sender must hold a credit, so a full buffer never takes a write
  a_no_overflow: assert property (@(posedge CLK) disable iff (RST)
    in_vld |-> (fill[in_slice] != CNT_W'(BUF_DEPTH)));

  a_one_slot_kind: assert property (@(posedge CLK) disable iff (RST)
    $onehot0({iss.op_vld, iss.imm_vld}));

endmodule

// File: logic/wb_if.sv
`timescale 1ns/1ps

interface wb_if;
  import isa_pkg::*;
  import thread_pkg::*;

  // vld on every completion, wr only when the register is written
  logic        vld;
  logic        wr;
  slice_t      slice;
  reg_idx_t    sel;
  logic [31:0] data;
  flags_t      flags;

  modport unit (
    output vld,
    output wr,
    output slice,
    output sel,
    output data,
    output flags
  );

  modport sink (
    input vld,
    input wr,
    input slice,
    input sel,
    input data,
    input flags
  );

endinterface

// File: logic/issue_if.sv
`timescale 1ns/1ps

interface issue_if;
  import isa_pkg::*;
  import thread_pkg::*;

  // Slot owner is always the current slice
  slice_t   slice;
  logic     op_vld;
  op_word_t op;
  logic     imm_vld;
  imm_t     imm;

  modport sequencer (
    output slice,
    output op_vld,
    output op,
    output imm_vld,
    output imm
  );

  modport unit (
    input slice,
    input op_vld,
    input op,
    input imm_vld,
    input imm
  );

endinterface

// File: logic/thread_pkg.sv
package thread_pkg;

  // Hardware threads sharing the cluster in round robin
  localparam int NUM_SLICES = 4;
  localparam int SLICE_W    = $clog2(NUM_SLICES);

  typedef logic [SLICE_W-1:0] slice_t;

  // Registers per slice
  localparam int NUM_REGS = 8;
  localparam int REG_W    = $clog2(NUM_REGS);

  typedef logic [REG_W-1:0] reg_idx_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

  // Raw input word; bit 31 picks immediate prefix or operation
  typedef logic [31:0] word_t;

  localparam int IMM_BIT = 31;
  localparam int IMM_W   = 28;
  localparam int OP_W    = 15;

  typedef logic [IMM_W-1:0] imm_t;

  // 15-bit operation layout
  typedef struct packed {
    logic       imm_form;
    logic [4:0] opcode;
    logic [2:0] ra;
    logic [2:0] rb;
    logic [2:0] rc;
  } op_word_t;

  // Register class in 0x00..0x05, bit class in 0x10..0x17
  typedef enum logic [4:0] {
    OP_OR   = 5'h00,
    OP_XOR  = 5'h01,
    OP_CMP  = 5'h02,
    OP_ADD  = 5'h03,
    OP_SUB  = 5'h04,
    OP_AND  = 5'h05,
    OP_BSET = 5'h10,
    OP_BCLR = 5'h11,
    OP_SUBI = 5'h12,
    OP_ADDI = 5'h13,
    OP_SHL  = 5'h14,
    OP_SHR  = 5'h15,
    OP_ASR  = 5'h16,
    OP_SEXT = 5'h17
  } au_op_e;

  // Bit-class amount taken from register rb when this bit is set
  localparam logic [4:0] OP_REG_AMT  = 5'h08;
  // Immediate form only keeps the low four opcode bits
  localparam logic [4:0] OP_IMM_MASK = 5'h0F;

  typedef logic [3:0] flags_t;

  localparam int FLG_ZERO  = 0;
  localparam int FLG_NEG   = 1;
  localparam int FLG_SOVFL = 2;
  localparam int FLG_UOVFL = 3;

endpackage
